// File: Makefile
# Verilator build and run of the feature-value bank testbench
VERILATOR ?= verilator
TOP       ?= fv_bank_tb
SEED      ?= 1
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) -Mdir $(OBJ_DIR) -f sim.f
	$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/fv_bank_tb.sv
/* Testbench for the feature-value bank: write backs, edge PE reads and iteration streams.
   Every output beat is compared with a shadow copy of the SRAM contents. */
`timescale 1ns/1ps

module fv_bank_tb
    import fv_bank_pkg::*;
();

    localparam int TIMEOUT = 200;
    localparam int SEED    = 32'h5429c84e;

    logic       clk;
    logic       reset;
    iter_t      replay_iter;
    iter_t      update_iter;
    fv_num_t    fv_num;
    logic       stream_begin;
    fv_req_t    req;
    fv_stream_t stream_out;
    fv_edge_t   edge_out;

    fv_line_t   shadow [2**ADDR_W];
    fv_stream_t exp_stream [$];
    fv_edge_t   exp_edge [$];
    int         errors       = 0;
    int         stream_beats = 0;
    int         edge_beats   = 0;
    logic       quiet        = 1'b1;
    logic       was_reset    = 1'b0;
    logic       s_open       = 1'b0;
    logic       e_open       = 1'b0;

    fv_clk_gen fv_clk_gen_i (
        .clk   (clk),
        .reset (reset)
    );

    fv_bank_top fv_bank_top_i (
        .clk          (clk),
        .reset        (reset),
        .replay_iter  (replay_iter),
        .update_iter  (update_iter),
        .fv_num       (fv_num),
        .stream_begin (stream_begin),
        .req          (req),
        .stream_out   (stream_out),
        .edge_out     (edge_out)
    );

    // Two features per line, rounded up, never below one line
    function automatic int num_lines(input fv_num_t n);
        int lines;
        lines = (int'(n) + 1) / 2;
        return (lines == 0) ? 1 : lines;
    endfunction

    function automatic fv_line_t expected_line(input iter_t iter, input node_idx_t node,
                                               input line_idx_t line);
        return shadow[{iter, node, line}];
    endfunction

    task automatic check(input string name, input fv_line_t got, input fv_line_t exp);
        if (got !== exp) begin
            errors++;
            $display("Error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("Errors: %0d, stream beats: %0d, edge beats: %0d",
                 errors, stream_beats, edge_beats);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    task automatic wait_reset();
        int cycles;
        cycles = 0;
        while (reset !== 1'b0 && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles >= TIMEOUT) begin
            errors++;
            $display("Reset was never released");
            finish_run();
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while ((exp_stream.size() != 0 || exp_edge.size() != 0) && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles >= TIMEOUT) begin
            errors++;
            $display("Timeout with %0d stream and %0d edge beats still missing",
                     exp_stream.size(), exp_edge.size());
            finish_run();
        end
    endtask

    // Burst into lines 0..len-1 of one node, idle cycles between beats
    task automatic write_burst(input node_id_t id, input int len);
        fv_line_t data;
        int       i;
        for (i = 0; i < len; i++) begin
            req.valid = 1'b0;
            repeat ($urandom_range(0, 2)) @(negedge clk);
            data        = {$urandom, $urandom};
            req.valid   = 1'b1;
            req.rd_wr   = 1'b1;
            req.wr_eos  = (i == len - 1);
            req.node_id = id;
            req.data    = data;
            shadow[{id, line_idx_t'(i)}] = data;
            @(negedge clk);
        end
        req.valid = 1'b0;
    endtask

    task automatic edge_read(input node_id_t id, input pe_tag_t tag);
        fv_edge_t beat;
        int       n;
        int       l;
        n = num_lines(fv_num);
        for (l = 0; l < n; l++) begin
            beat.valid  = 1'b1;
            beat.sos    = (l == 0);
            beat.eos    = (l == n - 1);
            beat.pe_tag = tag;
            beat.data   = expected_line(id[3:2], id[1:0], line_idx_t'(l));
            exp_edge.push_back(beat);
        end
        req.valid   = 1'b1;
        req.rd_wr   = 1'b0;
        req.wr_eos  = 1'b0;
        req.node_id = id;
        req.pe_tag  = tag;
        @(negedge clk);
        req.valid = 1'b0;
        wait_drain();
    endtask

    // Node-then-line order over the four nodes of one iteration
    task automatic expect_stream(input iter_t iter);
        fv_stream_t beat;
        int         n;
        int         node;
        int         l;
        n = num_lines(fv_num);
        for (node = 0; node < 4; node++) begin
            for (l = 0; l < n; l++) begin
                beat.valid = 1'b1;
                beat.sos   = (node == 0 && l == 0);
                beat.eos   = (node == 3 && l == n - 1);
                beat.addr  = {node_idx_t'(node), line_idx_t'(l)};
                beat.data  = expected_line(iter, node_idx_t'(node), line_idx_t'(l));
                exp_stream.push_back(beat);
            end
        end
    endtask

    // Write then read of one node, none of which may take effect
    task automatic present_ignored(input node_id_t id);
        req.valid   = 1'b1;
        req.rd_wr   = 1'b1;
        req.wr_eos  = 1'b1;
        req.node_id = id;
        req.data    = {$urandom, $urandom};
        @(negedge clk);
        req.rd_wr = 1'b0;
        @(negedge clk);
        req.valid = 1'b0;
    endtask

    always @(posedge clk) begin
        fv_stream_t s_exp;
        fv_edge_t   e_exp;
        if (quiet && was_reset) begin
            check("sram_req.cen_n", fv_line_t'(fv_bank_top_i.sram_req.cen_n), fv_line_t'(1'b1));
            check("sram_req.wen_n", fv_line_t'(fv_bank_top_i.sram_req.wen_n), fv_line_t'(1'b1));
            check("stream_out valid/sos/eos",
                  fv_line_t'({stream_out.valid, stream_out.sos, stream_out.eos}), '0);
            check("edge_out valid/sos/eos",
                  fv_line_t'({edge_out.valid, edge_out.sos, edge_out.eos}), '0);
        end
        if (stream_out.valid === 1'b1) begin
            if (exp_stream.size() == 0) begin
                errors++;
                $display("Stream beat seen while no stream beat was expected");
            end else begin
                s_exp = exp_stream.pop_front();
                stream_beats++;
                check("stream_out.sos", fv_line_t'(stream_out.sos), fv_line_t'(s_exp.sos));
                check("stream_out.eos", fv_line_t'(stream_out.eos), fv_line_t'(s_exp.eos));
                check("stream_out.addr", fv_line_t'(stream_out.addr), fv_line_t'(s_exp.addr));
                check("stream_out.data", stream_out.data, s_exp.data);
            end
        end else if (s_open) begin
            errors++;
            $display("Stream paused before its last beat");
        end
        if (edge_out.valid === 1'b1) begin
            if (exp_edge.size() == 0) begin
                errors++;
                $display("Edge beat seen while no edge read was pending");
            end else begin
                e_exp = exp_edge.pop_front();
                edge_beats++;
                check("edge_out.sos", fv_line_t'(edge_out.sos), fv_line_t'(e_exp.sos));
                check("edge_out.eos", fv_line_t'(edge_out.eos), fv_line_t'(e_exp.eos));
                check("edge_out.pe_tag", fv_line_t'(edge_out.pe_tag), fv_line_t'(e_exp.pe_tag));
                check("edge_out.data", edge_out.data, e_exp.data);
            end
        end else if (e_open) begin
            errors++;
            $display("Edge read paused before its last beat");
        end
        s_open = (stream_out.valid === 1'b1) && (stream_out.eos !== 1'b1);
        e_open = (edge_out.valid === 1'b1) && (edge_out.eos !== 1'b1);
        if (reset === 1'b1) begin
            was_reset = 1'b1;
        end
    end

    initial begin
        fv_num_t odd_nums [3] = '{5'd1, 5'd7, 5'd15};
        int      i;
        void'($urandom(SEED));
        replay_iter  = '0;
        update_iter  = '0;
        fv_num       = 5'd16;
        stream_begin = 1'b0;
        req          = '0;
        wait_reset();
        repeat (4) @(negedge clk);
        quiet = 1'b0;

        // Full bursts first so every line holds known data
        for (i = 0; i < 16; i++) begin
            write_burst(node_id_t'(i), 8);
        end
        for (i = 0; i < 16; i++) begin
            write_burst(node_id_t'(i), $urandom_range(1, 8));
        end
        for (i = 0; i < 16; i++) begin
            edge_read(node_id_t'(i), pe_tag_t'($urandom_range(0, 3)));
        end

        // Odd feature counts round up to whole lines
        for (i = 0; i < 3; i++) begin
            fv_num = odd_nums[i];
            @(negedge clk);
            edge_read(node_id_t'($urandom_range(0, 15)), pe_tag_t'(i));
        end

        // Stream of iteration 0 on stream_begin
        fv_num      = 5'd11;
        update_iter = 2'd1;
        @(negedge clk);
        expect_stream(2'd0);
        stream_begin = 1'b1;
        @(negedge clk);
        stream_begin = 1'b0;
        wait_drain();

        // New replay iteration, requests in the update phase are dropped
        fv_num = 5'd16;
        @(negedge clk);
        expect_stream(2'd2);
        replay_iter = 2'd2;
        @(negedge clk);
        present_ignored(4'd5);
        wait_drain();
        present_ignored(4'd5);
        repeat (4) @(negedge clk);
        update_iter = 2'd2;
        @(negedge clk);
        edge_read(4'd5, 2'd3);
        finish_run();
    end

endmodule

// File: bench/fv_clk_gen.sv
/* Testbench clock with a 10 ns period and a synchronous reset for the first 3 cycles. */
`timescale 1ns/1ps

module fv_clk_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // Three rising edges in reset, release on a falling edge
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// File: hdl/fv_bank_fsm.sv
/* Feature-value bank controller: iteration streaming, write-back bursts and edge PE reads.
   Drives the SRAM port and steers the line counter; output beats trail their reads by one cycle. */
`timescale 1ns/1ps

module fv_bank_fsm
    import fv_bank_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  iter_t        replay_iter,
    input  iter_t        update_iter,
    input  logic         stream_begin,
    input  fv_num_t      fv_num,
    input  fv_req_t      req,
    input  fv_line_t     rd_data,
    input  line_idx_t    line_idx,
    input  node_idx_t    node_idx,
    input  logic         last_line,
    input  logic         last_node,
    output logic         load,
    output logic         step_line,
    output logic         step_node,
    output fv_sram_req_t sram_req,
    output fv_stream_t   stream_out,
    output fv_edge_t     edge_out
);

    fv_bank_state_e state, nx_state;
    iter_t          cur_iter, nx_iter;
    node_id_t       node_id, nx_node_id;
    pe_tag_t        pe_tag, nx_pe_tag;

    // Flags of the read issued in this cycle
    logic                             s_valid, s_sos, s_eos;
    logic [NODE_IDX_W+LINE_IDX_W-1:0] s_addr;
    logic                             e_valid, e_sos, e_eos;

    // Same flags one cycle on, aligned with rd_data
    logic                             s_valid_q, s_sos_q, s_eos_q;
    logic [NODE_IDX_W+LINE_IDX_W-1:0] s_addr_q;
    logic                             e_valid_q, e_sos_q, e_eos_q;

    always_comb begin
        nx_state       = state;
        nx_iter        = cur_iter;
        nx_node_id     = node_id;
        nx_pe_tag      = pe_tag;
        load           = 1'b0;
        step_line      = 1'b0;
        step_node      = 1'b0;
        sram_req.cen_n = 1'b1;
        sram_req.wen_n = 1'b1;
        sram_req.addr  = '0;
        sram_req.data  = '0;
        s_valid        = 1'b0;
        s_sos          = 1'b0;
        s_eos          = 1'b0;
        s_addr         = {node_idx, line_idx};
        e_valid        = 1'b0;
        e_sos          = 1'b0;
        e_eos          = 1'b0;

        case (state)
            IDLE: begin
                if (update_iter[0]) begin
                    if (stream_begin || (replay_iter != cur_iter)) begin
                        load           = 1'b1;
                        nx_iter        = replay_iter;
                        nx_state       = STREAM;
                        sram_req.cen_n = 1'b0;
                        sram_req.addr  = {replay_iter, node_idx_t'(0), line_idx_t'(0)};
                        s_valid        = 1'b1;
                        s_sos          = 1'b1;
                        s_addr         = '0;
                        // Four nodes per bank, first beat never closes the stream
                        if (last_line) begin
                            step_node = 1'b1;
                        end else begin
                            step_line = 1'b1;
                        end
                    end
                end else if (req.valid) begin
                    load           = 1'b1;
                    nx_node_id     = req.node_id;
                    sram_req.cen_n = 1'b0;
                    sram_req.addr  = {req.node_id, line_idx_t'(0)};
                    if (req.rd_wr) begin
                        sram_req.wen_n = 1'b0;
                        sram_req.data  = req.data;
                        if (!req.wr_eos) begin
                            step_line = 1'b1;
                            nx_state  = WRITE_BACK;
                        end
                    end else begin
                        nx_pe_tag = req.pe_tag;
                        e_valid   = 1'b1;
                        e_sos     = 1'b1;
                        e_eos     = last_line;
                        if (!last_line) begin
                            step_line = 1'b1;
                            nx_state  = EDGE_READ;
                        end
                    end
                end
            end
            STREAM: begin
                sram_req.cen_n = 1'b0;
                sram_req.addr  = {cur_iter, node_idx, line_idx};
                s_valid        = 1'b1;
                if (last_line && last_node) begin
                    s_eos    = 1'b1;
                    nx_state = IDLE;
                end else if (last_line) begin
                    step_node = 1'b1;
                end else begin
                    step_line = 1'b1;
                end
            end
            WRITE_BACK: begin
                // Idle beats just hold the line position
                if (req.valid) begin
                    sram_req.cen_n = 1'b0;
                    sram_req.wen_n = 1'b0;
                    sram_req.addr  = {node_id, line_idx};
                    sram_req.data  = req.data;
                    if (req.wr_eos) begin
                        nx_state = IDLE;
                    end else begin
                        step_line = 1'b1;
                    end
                end
            end
            EDGE_READ: begin
                sram_req.cen_n = 1'b0;
                sram_req.addr  = {node_id, line_idx};
                e_valid        = 1'b1;
                e_eos          = last_line;
                if (last_line) begin
                    nx_state = IDLE;
                end else begin
                    step_line = 1'b1;
                end
            end
            default: nx_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            cur_iter  <= '0;
            s_valid_q <= 1'b0;
            s_sos_q   <= 1'b0;
            s_eos_q   <= 1'b0;
            e_valid_q <= 1'b0;
            e_sos_q   <= 1'b0;
            e_eos_q   <= 1'b0;
        end else begin
            state     <= nx_state;
            cur_iter  <= nx_iter;
            s_valid_q <= s_valid;
            s_sos_q   <= s_sos;
            s_eos_q   <= s_eos;
            e_valid_q <= e_valid;
            e_sos_q   <= e_sos;
            e_eos_q   <= e_eos;
        end
    end

    always_ff @(posedge clk) begin
        node_id  <= nx_node_id;
        pe_tag   <= nx_pe_tag;
        s_addr_q <= s_addr;
    end

    assign stream_out.valid = s_valid_q;
    assign stream_out.sos   = s_sos_q;
    assign stream_out.eos   = s_eos_q;
    assign stream_out.addr  = s_addr_q;
    assign stream_out.data  = rd_data;

    // Tag register only changes on a new request, so it still matches the last beat
    assign edge_out.valid  = e_valid_q;
    assign edge_out.sos    = e_sos_q;
    assign edge_out.eos    = e_eos_q;
    assign edge_out.pe_tag = pe_tag;
    assign edge_out.data   = rd_data;

    assert property (@(posedge clk) disable iff (reset)
        !(stream_out.valid && edge_out.valid))
        else $error("stream and edge beats overlap");

    // Feature count is a per-phase setting and holds while a node is read out
    assert property (@(posedge clk) disable iff (reset)
        (state inside {STREAM, EDGE_READ}) |-> $stable(fv_num))
        else $error("fv_num changed during a read sequence");

endmodule

// File: hdl/fv_bank_pkg.sv
/* Widths, vector types, bus structs and controller states of the feature-value bank.
   Every RTL module of the bank imports this package. */
package fv_bank_pkg;

    // Bank geometry
    localparam int FV_LINE_W  = 64;
    localparam int LINE_IDX_W = 3;
    localparam int NODE_IDX_W = 2;
    localparam int ITER_W     = 2;
    localparam int NODE_ID_W  = 4;
    localparam int ADDR_W     = 7;
    localparam int FV_NUM_W   = 5;
    localparam int PE_TAG_W   = 2;

    typedef logic [FV_LINE_W-1:0]  fv_line_t;
    typedef logic [ADDR_W-1:0]     fv_addr_t;
    typedef logic [LINE_IDX_W-1:0] line_idx_t;
    typedef logic [NODE_IDX_W-1:0] node_idx_t;
    typedef logic [ITER_W-1:0]     iter_t;
    typedef logic [NODE_ID_W-1:0]  node_id_t;
    typedef logic [FV_NUM_W-1:0]   fv_num_t;
    typedef logic [PE_TAG_W-1:0]   pe_tag_t;

    // Write-back beat or edge PE read, rd_wr high for write back
    typedef struct packed {
        logic     valid;
        logic     rd_wr;
        logic     wr_eos;
        node_id_t node_id;
        pe_tag_t  pe_tag;
        fv_line_t data;
    } fv_req_t;

    typedef struct packed {
        logic     cen_n;
        logic     wen_n;
        fv_addr_t addr;
        fv_line_t data;
    } fv_sram_req_t;

    // Beat towards the small feature-value bank, addr is {node, line}
    typedef struct packed {
        logic                             valid;
        logic                             sos;
        logic                             eos;
        logic [NODE_IDX_W+LINE_IDX_W-1:0] addr;
        fv_line_t                         data;
    } fv_stream_t;

    typedef struct packed {
        logic     valid;
        logic     sos;
        logic     eos;
        pe_tag_t  pe_tag;
        fv_line_t data;
    } fv_edge_t;

    typedef enum logic [1:0] {
        IDLE,
        STREAM,
        WRITE_BACK,
        EDGE_READ
    } fv_bank_state_e;

endpackage

// File: hdl/fv_bank_top.sv
/* Feature-value bank: controller, line counter and SRAM macro model.
   Streams an iteration to the small bank, takes write backs and serves edge PE reads. */
`timescale 1ns/1ps

module fv_bank_top
    import fv_bank_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  iter_t      replay_iter,
    input  iter_t      update_iter,
    input  fv_num_t    fv_num,
    input  logic       stream_begin,
    input  fv_req_t    req,
    output fv_stream_t stream_out,
    output fv_edge_t   edge_out
);

    fv_sram_req_t sram_req;
    fv_line_t     rd_data;
    logic         load;
    logic         step_line;
    logic         step_node;
    line_idx_t    line_idx;
    node_idx_t    node_idx;
    logic         last_line;
    logic         last_node;

    fv_bank_fsm fv_bank_fsm_i (
        .clk          (clk),
        .reset        (reset),
        .replay_iter  (replay_iter),
        .update_iter  (update_iter),
        .stream_begin (stream_begin),
        .fv_num       (fv_num),
        .req          (req),
        .rd_data      (rd_data),
        .line_idx     (line_idx),
        .node_idx     (node_idx),
        .last_line    (last_line),
        .last_node    (last_node),
        .load         (load),
        .step_line    (step_line),
        .step_node    (step_node),
        .sram_req     (sram_req),
        .stream_out   (stream_out),
        .edge_out     (edge_out)
    );

    fv_line_counter fv_line_counter_i (
        .clk       (clk),
        .reset     (reset),
        .load      (load),
        .step_line (step_line),
        .step_node (step_node),
        .fv_num    (fv_num),
        .line_idx  (line_idx),
        .node_idx  (node_idx),
        .last_line (last_line),
        .last_node (last_node)
    );

    fv_sram_bank fv_sram_bank_i (
        .clk      (clk),
        .sram_req (sram_req),
        .rd_data  (rd_data)
    );

endmodule

// File: hdl/fv_line_counter.sv
/* Line and node position counters for the bank controller.
   load restarts at line 0 of node 0 and latches the line count taken from fv_num. */
`timescale 1ns/1ps

module fv_line_counter
    import fv_bank_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      load,
    input  logic      step_line,
    input  logic      step_node,
    input  fv_num_t   fv_num,
    output line_idx_t line_idx,
    output node_idx_t node_idx,
    output logic      last_line,
    output logic      last_node
);

    logic [LINE_IDX_W:0] lines;
    logic [LINE_IDX_W:0] lines_new;
    logic [LINE_IDX_W:0] lines_eff;
    fv_num_t             fv_num_up;
    line_idx_t           line_base;
    node_idx_t           node_base;

    // Two features per line, rounded up, at least one line
    always_comb begin
        fv_num_up = fv_num + fv_num_t'(1);
        lines_new = fv_num_up[FV_NUM_W-1:1];
        if (lines_new == '0) begin
            lines_new = 1;
        end
    end

    // On load the flags already refer to the fresh position and count
    assign lines_eff = load ? lines_new : lines;
    assign line_base = load ? '0 : line_idx;
    assign node_base = load ? '0 : node_idx;

    assign last_line = ({1'b0, line_base} == lines_eff - 1'b1);
    assign last_node = (node_base == '1);

    always_ff @(posedge clk) begin
        if (reset) begin
            lines    <= 1;
            line_idx <= '0;
            node_idx <= '0;
        end else begin
            if (load) begin
                lines <= lines_new;
            end
            line_idx <= line_base;
            node_idx <= node_base;
            if (step_node) begin
                line_idx <= '0;
                node_idx <= node_base + 1'b1;
            end else if (step_line) begin
                line_idx <= line_base + 1'b1;
            end
        end
    end

    // Also covers write back, so a burst must fit the current feature count
    assert property (@(posedge clk) disable iff (reset) {1'b0, line_idx} < lines)
        else $error("line index ran past the latched line count");

endmodule

// File: hdl/fv_sram_bank.sv
/* Behavioral model of the single-port feature-value SRAM macro.
   Active-low chip and write enables, read data valid one cycle after the read. */
`timescale 1ns/1ps

module fv_sram_bank
    import fv_bank_pkg::*;
(
    input  logic         clk,
    input  fv_sram_req_t sram_req,
    output fv_line_t     rd_data
);

    // 128 lines: 4 iterations x 4 nodes x 8 lines
    fv_line_t mem [2**ADDR_W];

    always_ff @(posedge clk) begin
        if (!sram_req.cen_n) begin
            if (!sram_req.wen_n) begin
                mem[sram_req.addr] <= sram_req.data;
            end else begin
                // Read data holds until the next read
                rd_data <= mem[sram_req.addr];
            end
        end
    end

    // Controller must present a resolved address on every access
    assert property (@(posedge clk)
        !sram_req.cen_n |-> !$isunknown(sram_req.addr))
        else $error("SRAM access with unknown address");

endmodule

// File: sim.f
hdl/fv_bank_pkg.sv
hdl/fv_sram_bank.sv
hdl/fv_line_counter.sv
hdl/fv_bank_fsm.sv
hdl/fv_bank_top.sv
bench/fv_clk_gen.sv
bench/fv_bank_tb.sv
